/* common/pit_bus_pkg.sv */
// host bus side of the timer: address type, address map and the
// decoded access struct passed from the decode stage to the channels
package pit_bus_pkg;

    // ------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------

    localparam int DATA_W = 8;          // host data bus width

    typedef logic [1:0] pit_addr_t;     // 0..2 counters, 3 control word

    localparam pit_addr_t ADDR_CTRL = 2'd3;

    // ------------------------------------------------------------------
    // registered access, one per clk at most
    // ------------------------------------------------------------------

    // for a control word, chan carries din[7:6] instead of the address;
    // a read of address 3 keeps chan = 3 so only the read mux sees it
    typedef struct packed {
        logic              wr;      // write strobe, one cycle
        logic              rd;      // read strobe, one cycle
        logic              ctrl;    // write targets a control register
        pit_addr_t         chan;    // target channel
        logic [DATA_W-1:0] data;    // write byte
    } pit_access_t;

endpackage

/* common/pit_timer_pkg.sv */
// counter side of the timer: channel count, control word layout,
// read/load format and mode encodings, counter value type
package pit_timer_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------

    localparam int NUM_CHAN = 3;        // counters 0..2
    localparam int COUNT_W  = 16;       // counter and reload width

    typedef logic [COUNT_W-1:0] pit_count_t;

    // ------------------------------------------------------------------
    // control word fields, bits 5:0 of the written byte
    // ------------------------------------------------------------------

    // read/load format, RL_LATCH doubles as the counter latch command
    typedef enum logic [1:0] {
        RL_LATCH = 2'd0,
        RL_LSB   = 2'd1,
        RL_MSB   = 2'd2,
        RL_BOTH  = 2'd3
    } pit_rl_t;

    // modes 6 and 7 behave as 2 and 3
    typedef enum logic [2:0] {
        MODE_0 = 3'd0,      // interrupt on terminal count
        MODE_1 = 3'd1,      // gated one-shot, free running here
        MODE_2 = 3'd2,      // rate generator
        MODE_3 = 3'd3,      // square wave
        MODE_4 = 3'd4,      // software strobe
        MODE_5 = 3'd5,      // gated strobe, free running here
        MODE_6 = 3'd6,
        MODE_7 = 3'd7
    } pit_mode_t;

    typedef struct packed {
        pit_rl_t   rl;      // read/load format
        pit_mode_t mode;    // counting mode
        logic      bcd;     // kept, binary counting only
    } pit_cw_t;

endpackage

/* src/pit_bus_decode.sv */
// bus decode stage: qualifies cs/rd/wr and registers one decoded access
`timescale 1ns/1ps

module pit_bus_decode
    import pit_bus_pkg::*;
    import pit_timer_pkg::*;
(
    input  logic        clk,
    input  logic        cwset,
    input  logic        cs,
    input  logic        rd,
    input  logic        wr,
    input  pit_addr_t   a,
    input  logic [7:0]  din,
    output pit_access_t acc
);

    pit_access_t acc_nxt;   // decoded access for the coming edge
    logic        cw_valid;  // control word selects a real counter

    // select code 3 is the read-back command, not supported
    assign cw_valid = (int'(din[7:6]) < NUM_CHAN);

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------

    always_comb begin
        acc_nxt      = '0;
        acc_nxt.data = din;                         // carried along, only used on writes
        if (cs && wr) begin
            if (a == ADDR_CTRL) begin
                if (cw_valid) begin
                    acc_nxt.wr   = 1'b1;
                    acc_nxt.ctrl = 1'b1;
                    acc_nxt.chan = pit_addr_t'(din[7:6]);   // counter select bits
                end
            end else begin
                acc_nxt.wr   = 1'b1;                // data byte to a counter
                acc_nxt.chan = a;
            end
        end else if (cs && rd) begin
            // address 3 matches no channel, the mux answers with zero
            acc_nxt.rd   = 1'b1;
            acc_nxt.chan = a;
        end
    end

    // ------------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge cwset) begin
        if (cwset) begin
            acc <= '0;      // no strobes out of reset
        end else begin
            acc <= acc_nxt;
        end
    end

endmodule

/* channel/pit_channel_read.sv */
// per-channel read side: counter latch register and lsb/msb read order
`timescale 1ns/1ps

module pit_channel_read
    import pit_timer_pkg::*;
(
    input  logic       clk,
    input  logic       cwset,
    input  logic       cw_write,    // new control word, restart with lsb
    input  logic       latch_cmd,   // counter latch command
    input  logic       rd_strobe,   // byte taken by the read mux this edge
    input  pit_rl_t    rl,
    input  pit_count_t count,
    output logic [7:0] rd_byte
);

    pit_count_t latch_q;    // frozen count
    pit_count_t src;        // value the next byte comes from
    logic       latched;    // latch held until its last byte is read
    logic       read_msb;   // RL_BOTH: next read returns the msb
    logic       last_byte;  // this read ends the sequence

    assign src = latched ? latch_q : count;

    // RL_LATCH only shows up unprogrammed, it reads as lsb
    always_comb begin
        if ((rl == RL_MSB) || ((rl == RL_BOTH) && read_msb))
            rd_byte = src[15:8];
        else
            rd_byte = src[7:0];
    end

    assign last_byte = (rl != RL_BOTH) || read_msb;

    // ------------------------------------------------------------------
    // latch register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (latch_cmd && !latched)
            latch_q <= count;       // repeated latch before a read is ignored
    end

    // ------------------------------------------------------------------
    // read sequence
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge cwset) begin
        if (cwset) begin
            latched  <= 1'b0;
            read_msb <= 1'b0;
        end else if (cw_write) begin
            latched  <= 1'b0;
            read_msb <= 1'b0;
        end else begin
            if (latch_cmd)
                latched <= 1'b1;
            else if (rd_strobe && last_byte)
                latched <= 1'b0;    // release after the final byte
            if (rd_strobe && (rl == RL_BOTH))
                read_msb <= !read_msb;
        end
    end

endmodule

/* channel/pit_channel.sv */
// one timer channel: control register, reload value, down counter and
// out pin for modes 0, 2, 3 and 4; modes 1 and 5 count with out high
`timescale 1ns/1ps

module pit_channel
    import pit_bus_pkg::*;
    import pit_timer_pkg::*;
#(
    parameter int CHAN = 0      // channel index, 0..NUM_CHAN-1
) (
    input  logic        clk,
    input  logic        cwset,
    input  pit_access_t acc,
    output logic [7:0]  rd_byte,
    output logic        out
);

    pit_cw_t    cw;             // current control word
    pit_cw_t    cw_new;         // control word carried by this access
    pit_mode_t  mode_eff;       // mode with 6/7 folded onto 2/3
    pit_count_t reload;         // value written by the host
    pit_count_t count;          // down counter
    pit_count_t step;           // decrement for this clk
    pit_count_t count_dec;
    pit_count_t count_nxt;
    logic       msb_next;       // RL_BOTH: next data byte is the MSB
    logic       load_pend;      // reload complete, counter loads next edge
    logic       load_done;
    logic       running;        // held until the first load after a control word
    logic       tc;             // count has passed 1 -> 0 since the load
    logic       sel;
    logic       cw_hit;
    logic       cw_write;
    logic       latch_cmd;
    logic       data_wr;
    logic       rd_strobe;

    // ------------------------------------------------------------------
    // access qualification
    // ------------------------------------------------------------------

    assign sel       = (acc.chan == pit_addr_t'(CHAN));
    assign cw_new    = pit_cw_t'(acc.data[5:0]);
    assign cw_hit    = acc.wr && acc.ctrl && sel;
    assign latch_cmd = cw_hit && (cw_new.rl == RL_LATCH);   // latch, cw untouched
    assign cw_write  = cw_hit && (cw_new.rl != RL_LATCH);
    assign data_wr   = acc.wr && !acc.ctrl && sel;
    assign rd_strobe = acc.rd && !acc.ctrl && sel;

    // single byte formats finish at once, RL_BOTH on the msb
    assign load_done = data_wr && ((cw.rl == RL_LSB) || (cw.rl == RL_MSB) ||
                                   ((cw.rl == RL_BOTH) && msb_next));

    assign mode_eff = cw.mode[1] ? pit_mode_t'({1'b0, cw.mode[1:0]}) : cw.mode;

    // ------------------------------------------------------------------
    // next count
    // ------------------------------------------------------------------

    // mode 3: an odd value drops by 1 in the high half and by 3 in the
    // low half, so the high half is one clk longer
    always_comb begin
        step = pit_count_t'(1);
        if (mode_eff == MODE_3) begin
            if (!count[0])
                step = pit_count_t'(2);
            else if (!out)
                step = pit_count_t'(3);
        end
    end

    assign count_dec = count - step;

    always_comb begin
        case (mode_eff)
            MODE_2:  count_nxt = (count == pit_count_t'(1)) ? reload : count_dec;
            MODE_3:  count_nxt = (count_dec == '0) ? reload : count_dec;
            default: count_nxt = count_dec;         // modes 0/1/4/5 wrap, no reload
        endcase
    end

    // ------------------------------------------------------------------
    // reload value
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (data_wr) begin
            case (cw.rl)
                RL_LSB:  reload <= {8'h00, acc.data};
                RL_MSB:  reload <= {acc.data, 8'h00};
                RL_BOTH: begin
                    if (msb_next)
                        reload[15:8] <= acc.data;
                    else
                        reload[7:0] <= acc.data;
                end
                default: ;                          // unprogrammed, byte ignored
            endcase
        end
    end

    // ------------------------------------------------------------------
    // control, counter and out
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge cwset) begin
        if (cwset) begin
            cw        <= '{rl: RL_LATCH, mode: MODE_0, bcd: 1'b0};
            msb_next  <= 1'b0;
            load_pend <= 1'b0;
            running   <= 1'b0;
            tc        <= 1'b0;
            count     <= '0;
            out       <= 1'b1;
        end else if (cw_write) begin
            cw        <= cw_new;
            msb_next  <= 1'b0;
            load_pend <= 1'b0;
            running   <= 1'b0;                      // wait for a new count
            tc        <= 1'b0;
            out       <= (cw_new.mode != MODE_0);   // mode 0 drops out at once
        end else begin
            if (data_wr && (cw.rl == RL_BOTH))
                msb_next <= !msb_next;
            load_pend <= load_done;
            if (load_pend) begin
                count   <= reload;                  // 0 acts as 65536
                running <= 1'b1;
                tc      <= 1'b0;
                out     <= (mode_eff != MODE_0);
            end else if (running) begin
                count <= count_nxt;
                if (count == pit_count_t'(1))
                    tc <= 1'b1;
                case (mode_eff)
                    MODE_0: if (tc) out <= 1'b1;     // high one clk after reaching 0
                    MODE_2: out <= (count_nxt != pit_count_t'(1));
                    MODE_3: if (count_dec == '0) out <= !out;   // toggle on reload
                    MODE_4: out <= !((count == pit_count_t'(1)) && !tc);
                    default: out <= 1'b1;           // no gate, out parked high
                endcase
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    pit_channel_read u_read (
        .clk       (clk),
        .cwset     (cwset),
        .cw_write  (cw_write),
        .latch_cmd (latch_cmd),
        .rd_strobe (rd_strobe),
        .rl        (cw.rl),
        .count     (count),
        .rd_byte   (rd_byte)
    );

endmodule

/* src/pit_read_mux.sv */
// read mux stage: picks the addressed channel byte and registers dout
`timescale 1ns/1ps

module pit_read_mux
    import pit_bus_pkg::*;
    import pit_timer_pkg::*;
(
    input  logic                     clk,
    input  logic                     cwset,
    input  pit_access_t              acc,
    input  logic [NUM_CHAN-1:0][7:0] rd_bytes,
    output logic [7:0]               dout,
    output logic                     rd_valid
);

    // strobe, one cycle after the decode stage
    always_ff @(posedge clk or posedge cwset) begin
        if (cwset)
            rd_valid <= 1'b0;
        else
            rd_valid <= acc.rd;
    end

    // data byte, held between reads
    always_ff @(posedge clk) begin
        if (acc.rd) begin
            if (acc.chan == ADDR_CTRL)
                dout <= '0;                     // control register is write only
            else
                dout <= rd_bytes[acc.chan];     // same edge the channel steps its sequence
        end
    end

endmodule

/* src/pit_top.sv */
// timer top: decode stage, three counter channels, read mux
`timescale 1ns/1ps

module pit_top
    import pit_bus_pkg::*;
    import pit_timer_pkg::*;
(
    input  logic                clk,
    input  logic                cwset,
    input  logic                cs,
    input  logic                rd,
    input  logic                wr,
    input  pit_addr_t           a,
    input  logic [7:0]          din,
    output logic [7:0]          dout,
    output logic                rd_valid,
    output logic [NUM_CHAN-1:0] out
);

    pit_access_t              acc;          // registered bus access
    logic [NUM_CHAN-1:0][7:0] rd_bytes;     // per-channel read byte

    // ------------------------------------------------------------------
    // stage 1, bus decode
    // ------------------------------------------------------------------

    pit_bus_decode u_decode (
        .clk   (clk),
        .cwset (cwset),
        .cs    (cs),
        .rd    (rd),
        .wr    (wr),
        .a     (a),
        .din   (din),
        .acc   (acc)
    );

    // ------------------------------------------------------------------
    // stage 2, counters
    // ------------------------------------------------------------------

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        pit_channel #(
            .CHAN (i)
        ) u_chan (
            .clk     (clk),
            .cwset   (cwset),
            .acc     (acc),
            .rd_byte (rd_bytes[i]),
            .out     (out[i])
        );
    end

    // ------------------------------------------------------------------
    // stage 3, read mux
    // ------------------------------------------------------------------

    pit_read_mux u_rmux (
        .clk      (clk),
        .cwset    (cwset),
        .acc      (acc),
        .rd_bytes (rd_bytes),
        .dout     (dout),
        .rd_valid (rd_valid)
    );

endmodule

/* test/pit_tb_tasks.svh */
// testbench helpers: clock step, bus accesses, error reports and the
// reference out timing of each mode
`ifndef PIT_TB_TASKS_SVH
`define PIT_TB_TASKS_SVH

// ----------------------------------------------------------------------
// reference models, clks counted from the edge that loads the counter
// ----------------------------------------------------------------------

function automatic int square_high_len(input int n);
    return (n + 1) / 2;                 // odd n keeps the extra clk high
endfunction

function automatic int square_low_len(input int n);
    return n / 2;
endfunction

function automatic int oneshot_rise(input int n);
    return n + 1;                       // mode 0 out high after count 0 is seen
endfunction

// mode 2 count d clks after a known count, sequence runs n down to 1
function automatic int rate_count_after(input int start, input int d, input int n);
    int t;
    t = start - 1 - (d % n);
    if (t < 0)
        t = t + n;
    return t + 1;
endfunction

function automatic int draw_reload();
    return 3 + int'($unsigned($random(seed)) % 32'd38);    // 3..40
endfunction

// ----------------------------------------------------------------------
// bus and reporting
// ----------------------------------------------------------------------

task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);                     // drive and sample point
endtask

task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("Fail %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
    err_count++;
endtask

task automatic report_problem(input string what);
    $display("Error in %s: %s", cur_test, what);
    err_count++;
endtask

task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
    last_wr_cyc = cyc;
    cs  = 1'b1;
    wr  = 1'b1;
    a   = addr;
    din = data;
    next_cycle();                       // one clk strobe
    cs  = 1'b0;
    wr  = 1'b0;
endtask

task automatic bus_read(input logic [1:0] addr, output logic [7:0] data);
    int waited;
    last_rd_cyc = cyc;
    cs = 1'b1;
    rd = 1'b1;
    a  = addr;
    next_cycle();
    cs = 1'b0;
    rd = 1'b0;
    waited = 0;
    while (!rd_valid && waited < 4) begin
        next_cycle();
        waited++;
    end
    assert (rd_valid) else report_problem("no rd_valid after a read");
    data = dout;
endtask

// waits for out[ch] == level, then counts the clks it stays there
task automatic run_length(input logic [1:0] ch, input logic level, input int limit,
                          output int len);
    int guard;
    guard = 0;
    while (out_pins[ch] != level && guard < limit) begin
        next_cycle();
        guard++;
    end
    len = 0;
    while (out_pins[ch] == level && len < limit) begin
        len++;
        next_cycle();
    end
endtask

task automatic check_square(input int n);
    int low_len;
    int high_len;
    bus_write(ADDR_CTRL, 8'h56);        // ch1, lsb only, mode 3
    bus_write(2'd1, n[7:0]);
    run_length(2'd1, 1'b0, 2 * MAX_N, low_len);
    run_length(2'd1, 1'b1, 2 * MAX_N, high_len);
    assert (low_len == square_low_len(n))
        else report_mismatch("low clks", square_low_len(n), low_len);
    assert (high_len == square_high_len(n))
        else report_mismatch("high clks", square_high_len(n), high_len);
endtask

`endif

/* test/pit_tb.sv */
// timer testbench with clock, reset, protocol and out checkers, the test
// sequence, watchdog and summary
`timescale 1ns/1ps

module pit_tb
    import pit_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_N        = 40;                   // largest random reload
    localparam int RUNS         = 7;                    // counting runs over all tests
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUNS * 4 * MAX_N + 400;

    logic       clk;
    logic       cwset;
    logic       cs;
    logic       rd;
    logic       wr;
    logic [1:0] a;
    logic [7:0] din;
    logic [7:0] dout;
    logic       rd_valid;
    logic [2:0] out_pins;

    integer seed;
    string  cur_test;
    int     err_count = 0;
    int     errs_at_start = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;
    int     cyc = 0;                                    // clk edges since time 0
    int     last_wr_cyc;
    int     last_rd_cyc;
    logic   ch2_used = 1'b0;
    int     rate_n = 0;                                 // 0 keeps the ch0 checker idle
    int     rate_gap = 0;
    int     rate_pulses = 0;
    logic   rate_seen = 1'b0;

    `include "pit_tb_tasks.svh"

    pit_top dut (
        .clk      (clk),
        .cwset    (cwset),
        .cs       (cs),
        .rd       (rd),
        .wr       (wr),
        .a        (a),
        .din      (din),
        .dout     (dout),
        .rd_valid (rd_valid),
        .out      (out_pins)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------------------------------------------
    // checkers
    // ------------------------------------------------------------------

    assert property (@(posedge clk) disable iff (cwset) rd_valid == $past(cs && rd, 2))
        else report_problem("rd_valid did not follow a read strobe by exactly two clks");

    // ch2 stays parked high until test 4 programs it
    assert property (@(posedge clk) disable iff (cwset || ch2_used) out_pins[2])
        else report_problem("out 2 dropped while channel 2 was unprogrammed");

    // mode 2 spacing on ch0 stays checked from test 2 to the end
    always @(posedge clk) begin
        if (rate_n == 0) begin
            rate_seen = 1'b0;
        end else if (!out_pins[0]) begin
            if (rate_seen) begin
                assert (rate_gap == rate_n)
                    else report_mismatch("pulse spacing", rate_n, rate_gap);
                rate_pulses++;
            end
            rate_seen = 1'b1;
            rate_gap  = 1;                              // one clk wide pulse expected
        end else begin
            rate_gap++;
        end
    end

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_count - errs_at_start;
        if (errs == 0) begin
            $display("test %s ok", cur_test);
            pass_tests++;
        end else begin
            $display("test %s FAILED with %0d errors", cur_test, errs);
            fail_tests++;
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        int n_rate;
        int n;
        int k;
        int lows;
        int low_at;
        int guard;
        int load_cyc;
        int latch_cyc;
        int live_cyc;
        int latched;
        int live;
        int expect_latch;
        int expect_live;
        logic [7:0] lo;
        logic [7:0] hi;
        seed  = 32'h5af06d4d;
        cwset = 1'b1;
        cs    = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        a     = 2'd0;
        din   = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        cwset = 1'b0;

        start_test("reset");
        assert (out_pins == 3'b111) else report_mismatch("out pins", 7, int'(out_pins));
        assert (!rd_valid) else report_problem("rd_valid high after reset");
        for (int i = 0; i < 3; i++)
            bus_read(2'(i), lo);                        // rd_valid checked by the property
        finish_test();

        start_test("mode2_rate");
        n_rate = draw_reload();
        bus_write(ADDR_CTRL, 8'h34);                    // ch0, lsb then msb, mode 2
        bus_write(2'd0, n_rate[7:0]);
        bus_write(2'd0, n_rate[15:8]);
        load_cyc = last_wr_cyc + 3;                     // ch0 holds n_rate from this clk on
        rate_n = n_rate;
        guard  = 0;
        while (rate_pulses < 3 && guard < 5 * MAX_N) begin
            next_cycle();
            guard++;
        end
        assert (rate_pulses >= 3) else report_problem("too few mode 2 pulses on out 0");
        finish_test();

        start_test("mode3_square");                     // ch1 while ch0 keeps running
        n = draw_reload();
        check_square(n[0] ? n + 1 : n);
        check_square(n[0] ? n : n - 1);
        finish_test();

        start_test("mode0_mode4");
        n = draw_reload();
        ch2_used = 1'b1;
        bus_write(ADDR_CTRL, 8'h90);                    // ch2, lsb only, mode 0
        bus_write(2'd2, n[7:0]);
        assert (!out_pins[2])
            else report_mismatch("out after control word", 0, int'(out_pins[2]));
        k = 0;
        while (!out_pins[2] && k < 2 * MAX_N) begin
            next_cycle();
            k++;
        end
        // counter loads two clks after the data byte
        assert (k - 2 == oneshot_rise(n))
            else report_mismatch("clks to out high", oneshot_rise(n), k - 2);
        lows = 0;
        repeat (2 * n) begin
            next_cycle();
            if (!out_pins[2])
                lows++;
        end
        assert (lows == 0) else report_mismatch("low clks after terminal count", 0, lows);
        n = draw_reload();
        bus_write(ADDR_CTRL, 8'h98);                    // ch2, lsb only, mode 4
        bus_write(2'd2, n[7:0]);
        lows   = 0;
        low_at = -1;
        for (int i = 1; i <= 3 * n + 4; i++) begin
            next_cycle();
            if (!out_pins[2]) begin
                lows++;
                if (low_at < 0)
                    low_at = i - 2;
            end
        end
        assert (lows == 1) else report_mismatch("strobe low clks", 1, lows);
        assert (low_at == n) else report_mismatch("clks from load to strobe", n, low_at);
        finish_test();

        start_test("latch");
        bus_write(ADDR_CTRL, 8'h00);                    // latch command for ch0
        latch_cyc = last_wr_cyc;
        bus_read(2'd0, lo);
        bus_read(2'd0, hi);
        latched      = int'({hi, lo});
        // latch and read mux both take the count one clk after the strobe
        expect_latch = rate_count_after(n_rate, latch_cyc + 1 - load_cyc, n_rate);
        assert (latched == expect_latch)
            else report_mismatch("latched count", expect_latch, latched);
        repeat (3) next_cycle();
        while (((cyc - latch_cyc) % n_rate) == 0)
            next_cycle();                               // live value must differ
        bus_read(2'd0, lo);
        live_cyc = last_rd_cyc;
        bus_read(2'd0, hi);
        live        = int'({hi, lo});
        expect_live = rate_count_after(n_rate, live_cyc + 1 - load_cyc, n_rate);
        assert (live == expect_live) else report_mismatch("live count", expect_live, live);
        assert (live != latched) else report_problem("live read returned the latched value");
        bus_read(ADDR_CTRL, lo);
        assert (lo == 8'h00) else report_mismatch("control address read", 0, int'(lo));
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog allows four periods of the largest reload per run plus margin
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clks", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

/* pit.f */
+incdir+test
common/pit_bus_pkg.sv
common/pit_timer_pkg.sv
src/pit_bus_decode.sv
channel/pit_channel_read.sv
channel/pit_channel.sv
src/pit_read_mux.sv
src/pit_top.sv
test/pit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the timer testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pit_tb -Mdir obj_dir -f pit.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

output=$(./obj_dir/Vpit_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
    exit 0
fi
exit 1
